/* machine_mode_top.f */
machine_csr_pkg.sv
csr_access.sv
csr_file.sv
trap_ctrl.sv
clint_timer.sv
clint_axil_regs.sv
machine_mode_top.sv
tb_machine_mode.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_machine_mode
RTL_TOP  = machine_mode_top
FILELIST = machine_mode_top.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_machine_mode.sv */
`timescale 1ns/100ps

module tb_machine_mode
    import machine_csr_pkg::*;
();

    localparam int TIMER_DIV = 4;
    localparam int CMP_AHEAD = 8;     // mtime ticks between programming and the interrupt
    // six tests at a few hundred cycles each, with margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       wr_mscrstch;
    logic       instr_valid;
    xlen_t      pc;
    csr_op_e    csr_op;
    csr_addr_t  csr_addr;
    xlen_t      csr_src;
    logic       ecall;
    logic       mret;
    logic       stall;
    xlen_t      csr_rdata;
    logic       redirect_valid;
    xlen_t      redirect_pc;
    bus_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    bus_data_t  wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    bus_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    bus_data_t  rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    int seed = 32'h1287_db1b;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    xlen_t tvec_exp;                  // mtvec programmed by the ecall test

    machine_mode_top #(
        .TIMER_DIV (TIMER_DIV)
    ) UUT (
        .clk            (clk),
        .wr_mscrstch    (wr_mscrstch),
        .instr_valid    (instr_valid),
        .pc             (pc),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_src        (csr_src),
        .ecall          (ecall),
        .mret           (mret),
        .stall          (stall),
        .csr_rdata      (csr_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .awaddr         (awaddr),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wvalid         (wvalid),
        .wready         (wready),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .araddr         (araddr),
        .arvalid        (arvalid),
        .arready        (arready),
        .rdata          (rdata),
        .rresp          (rresp),
        .rvalid         (rvalid),
        .rready         (rready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: simulation ran past %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp) else begin
            $display("error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("%-16s ok", name);
        end else begin
            $display("%-16s failed with %0d errors", name, errors - errs_before);
            tests_failed++;
        end
    endtask

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    // one instruction cycle, the write lands on the following edge
    task automatic issue_csr(input csr_op_e op, input csr_addr_t addr, input xlen_t src);
        @(posedge clk);
        instr_valid <= 1'b1;
        csr_op      <= op;
        csr_addr    <= addr;
        csr_src     <= src;
        @(posedge clk);
        instr_valid <= 1'b0;
        csr_op      <= CSR_NONE;
        csr_src     <= '0;
    endtask

    task automatic read_csr(input csr_addr_t addr, output xlen_t data);
        @(posedge clk);
        csr_addr <= addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input int hold,
                             output logic [1:0] resp);
        logic [1:0] first;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        first = bresp;
        repeat (hold) begin
            @(negedge clk);
            check_true(bvalid && bresp == first, "write response changed while bready was low");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        resp = first;
    endtask

    task automatic bus_read(input bus_addr_t addr, input int hold, output bus_data_t data,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b0;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check_true(rvalid && rdata == data && rresp == resp,
                       "read response changed while rready was low");
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic csr_access_test();
        int    errs;
        xlen_t model;
        xlen_t src;
        xlen_t got;
        errs = errors;
        read_csr(CSR_MSCRATCH, got);
        check_val("mscratch after reset", got, '0);
        model = rand_word();
        issue_csr(CSR_RW, CSR_MSCRATCH, model);
        read_csr(CSR_MSCRATCH, got);
        check_val("mscratch rw", got, model);
        src = rand_word();
        model = model | src;
        issue_csr(CSR_RS, CSR_MSCRATCH, src);
        read_csr(CSR_MSCRATCH, got);
        check_val("mscratch rs", got, model);
        src = rand_word();
        model = model & ~src;
        issue_csr(CSR_RC, CSR_MSCRATCH, src);
        read_csr(CSR_MSCRATCH, got);
        check_val("mscratch rc", got, model);
        // x0 source writes nothing, so mcycle keeps counting
        @(posedge clk);
        instr_valid <= 1'b1;
        csr_op      <= CSR_RS;
        csr_addr    <= CSR_MCYCLE;
        csr_src     <= '0;
        @(negedge clk);
        got = csr_rdata;
        @(posedge clk);
        instr_valid <= 1'b0;
        csr_op      <= CSR_NONE;
        @(negedge clk);
        check_val("mcycle rs x0", csr_rdata, got + 64'd1);
        read_csr(12'h7C0, got);
        check_val("unmapped csr", got, '0);
        report_test("csr access", errs);
    endtask

    task automatic field_mask_test();
        int    errs;
        xlen_t got;
        xlen_t status_exp;
        errs = errors;
        // sd, fs, mpp, mpie, mie
        status_exp = (64'd1 << 63) | (64'h3 << 13) | (64'h3 << 11) | (64'd1 << 7) | (64'd1 << 3);
        issue_csr(CSR_RW, CSR_MTVEC, '1);
        issue_csr(CSR_RW, CSR_MEPC, '1);
        issue_csr(CSR_RW, CSR_MIE, '1);
        issue_csr(CSR_RW, CSR_MSTATUS, '1);
        read_csr(CSR_MTVEC, got);
        check_val("mtvec", got, ~64'h3);
        read_csr(CSR_MEPC, got);
        check_val("mepc", got, ~64'h3);
        read_csr(CSR_MIE, got);
        check_val("mie", got, 64'h80);
        read_csr(CSR_MSTATUS, got);
        check_val("mstatus", got, status_exp);
        issue_csr(CSR_RW, CSR_MSTATUS, '0);
        issue_csr(CSR_RW, CSR_MIE, '0);
        report_test("field masking", errs);
    endtask

    task automatic ecall_mret_test();
        int    errs;
        xlen_t trap_pc;
        xlen_t got;
        errs = errors;
        tvec_exp = rand_word() & ~64'h3;
        trap_pc  = rand_word();
        issue_csr(CSR_RW, CSR_MTVEC, tvec_exp);
        issue_csr(CSR_RS, CSR_MSTATUS, 64'h8);
        @(posedge clk);
        instr_valid <= 1'b1;
        ecall       <= 1'b1;
        pc          <= trap_pc;
        @(negedge clk);
        check_val("redirect_valid", {63'd0, redirect_valid}, 64'd1);
        check_val("redirect_pc", redirect_pc, tvec_exp);
        @(posedge clk);
        instr_valid <= 1'b0;
        ecall       <= 1'b0;
        read_csr(CSR_MEPC, got);
        check_val("mepc", got, trap_pc & ~64'h3);
        read_csr(CSR_MCAUSE, got);
        check_val("mcause", got, 64'd11);
        read_csr(CSR_MSTATUS, got);
        check_val("mstatus after trap", got, 64'h1880); // mpp 3, mpie 1, mie 0
        @(posedge clk);
        instr_valid <= 1'b1;
        mret        <= 1'b1;
        @(negedge clk);
        check_val("redirect_valid", {63'd0, redirect_valid}, 64'd1);
        check_val("redirect_pc", redirect_pc, trap_pc & ~64'h3);
        @(posedge clk);
        instr_valid <= 1'b0;
        mret        <= 1'b0;
        read_csr(CSR_MSTATUS, got);
        check_val("mstatus after mret", got, 64'h88);
        // both requests under stall
        @(posedge clk);
        instr_valid <= 1'b1;
        stall       <= 1'b1;
        ecall       <= 1'b1;
        pc          <= trap_pc + 64'h40;
        @(negedge clk);
        check_val("redirect_valid stalled ecall", {63'd0, redirect_valid}, 64'd0);
        @(posedge clk);
        ecall <= 1'b0;
        mret  <= 1'b1;
        @(negedge clk);
        check_val("redirect_valid stalled mret", {63'd0, redirect_valid}, 64'd0);
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        mret        <= 1'b0;
        read_csr(CSR_MEPC, got);
        check_val("mepc after stall", got, trap_pc & ~64'h3);
        read_csr(CSR_MSTATUS, got);
        check_val("mstatus after stall", got, 64'h88);
        report_test("ecall and mret", errs);
    endtask

    task automatic timer_irq_test();
        int         errs;
        int         waited;
        int         bound;
        bus_data_t  now;
        logic [1:0] resp;
        xlen_t      got;
        errs  = errors;
        bound = (CMP_AHEAD + 2) * TIMER_DIV + 4;
        issue_csr(CSR_RS, CSR_MIE, 64'h80);
        issue_csr(CSR_RS, CSR_MSTATUS, 64'h8);
        bus_read(MTIME_LO, 0, now, resp);
        bus_write(MTIMECMP_LO, now + CMP_AHEAD, 0, resp);
        bus_write(MTIMECMP_HI, 32'h0, 0, resp);
        @(posedge clk);
        instr_valid <= 1'b1;
        csr_op      <= CSR_NONE;
        waited = 0;
        @(negedge clk);
        while (!redirect_valid && waited < bound) begin
            @(negedge clk);
            waited++;
        end
        check_true(redirect_valid, "timer interrupt did not redirect the core in time");
        check_val("redirect_pc", redirect_pc, tvec_exp);
        @(posedge clk);
        instr_valid <= 1'b0;
        read_csr(CSR_MCAUSE, got);
        check_val("mcause", got, CAUSE_MTIMER);
        read_csr(CSR_MIP, got);
        check_val("mip", got, 64'h80);
        bus_write(MTIMECMP_HI, 32'hFFFF_FFFF, 0, resp);
        issue_csr(CSR_RC, CSR_MIE, 64'h80);
        report_test("timer interrupt", errs);
    endtask

    task automatic axi_regs_test();
        int         errs;
        bus_data_t  lo;
        bus_data_t  hi;
        bus_data_t  got;
        bus_data_t  t1;
        logic [1:0] resp;
        errs = errors;
        lo = $random(seed);
        hi = $random(seed);
        bus_write(MTIMECMP_LO, lo, 3, resp);
        check_val("bresp", {62'd0, resp}, {62'd0, RESP_OKAY});
        bus_write(MTIMECMP_HI, hi, 0, resp);
        bus_read(MTIMECMP_LO, 3, got, resp);
        check_val("mtimecmp lo", {32'd0, got}, {32'd0, lo});
        check_val("rresp", {62'd0, resp}, {62'd0, RESP_OKAY});
        bus_read(MTIMECMP_HI, 0, got, resp);
        check_val("mtimecmp hi", {32'd0, got}, {32'd0, hi});
        bus_read(MTIME_LO, 0, t1, resp);
        repeat (10) @(posedge clk);
        bus_read(MTIME_LO, 0, got, resp);
        check_true(got >= t1, "mtime went backwards between two reads");
        bus_write(8'h20, 32'hDEAD_BEEF, 2, resp);
        check_val("bresp", {62'd0, resp}, {62'd0, RESP_SLVERR});
        bus_read(8'h20, 2, got, resp);
        check_val("rresp", {62'd0, resp}, {62'd0, RESP_SLVERR});
        bus_write(8'h28, 32'hDEAD_BEEF, 0, resp); // low bits alias mtimecmp lo
        check_val("bresp", {62'd0, resp}, {62'd0, RESP_SLVERR});
        bus_read(MTIMECMP_LO, 0, got, resp);
        check_val("mtimecmp lo after bad write", {32'd0, got}, {32'd0, lo});
        bus_write(MTIMECMP_HI, 32'hFFFF_FFFF, 0, resp);
        bus_write(MTIMECMP_LO, 32'hFFFF_FFFF, 0, resp);
        report_test("axi registers", errs);
    endtask

    task automatic mcycle_test();
        int    errs;
        xlen_t first;
        xlen_t second;
        xlen_t val;
        errs = errors;
        @(posedge clk);
        csr_addr <= CSR_MCYCLE;
        @(negedge clk);
        first = csr_rdata;
        @(negedge clk);
        second = csr_rdata;
        check_val("mcycle step", second, first + 64'd1);
        val = rand_word();
        @(posedge clk);
        instr_valid <= 1'b1;
        csr_op      <= CSR_RW;
        csr_src     <= val;
        @(posedge clk);
        instr_valid <= 1'b0;
        csr_op      <= CSR_NONE;
        @(negedge clk);
        check_val("mcycle written", csr_rdata, val);
        @(negedge clk);
        check_val("mcycle next", csr_rdata, val + 64'd1);
        report_test("mcycle", errs);
    endtask

    initial begin
        wr_mscrstch = 1'b1;
        instr_valid = 1'b0;
        pc          = '0;
        csr_op      = CSR_NONE;
        csr_addr    = '0;
        csr_src     = '0;
        ecall       = 1'b0;
        mret        = 1'b0;
        stall       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        repeat (4) @(posedge clk);
        wr_mscrstch <= 1'b0;
        @(negedge clk);
        check_true(!redirect_valid && !awready && !wready && !bvalid && !rvalid && arready,
                   "handshake outputs not in their reset state");

        csr_access_test();
        field_mask_test();
        ecall_mret_test();
        timer_irq_test();
        axi_regs_test();
        mcycle_test();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* machine_mode_top.sv */
`timescale 1ns/100ps

module machine_mode_top
    import machine_csr_pkg::*;
#(
    parameter int TIMER_DIV = 4
) (
    input  logic       clk,
    input  logic       wr_mscrstch,
    // core side
    input  logic       instr_valid,
    input  xlen_t      pc,
    input  csr_op_e    csr_op,
    input  csr_addr_t  csr_addr,
    input  xlen_t      csr_src,
    input  logic       ecall,
    input  logic       mret,
    input  logic       stall,
    output xlen_t      csr_rdata,
    output logic       redirect_valid,
    output xlen_t      redirect_pc,
    // timer bus
    input  bus_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  bus_data_t  wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  bus_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output bus_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready
);

    logic      wr_en;
    xlen_t     wr_data;
    logic      trap_take;
    logic      mret_take;
    xlen_t     trap_cause;
    logic      mstatus_mie;
    logic      mie_mtie;
    logic      mip_mtip;
    xlen_t     mtvec;
    xlen_t     mepc;
    logic      timer_pending;
    logic      wr_lo;
    logic      wr_hi;
    logic      cmp_lo;
    logic      cmp_hi;
    bus_data_t tmr_wdata;
    xlen_t     mtime;
    xlen_t     mtimecmp;

    csr_access u_csr_access (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .csr_op      (csr_op),
        .csr_src     (csr_src),
        .old_value   (csr_rdata),
        .stall       (stall),
        .instr_valid (instr_valid),
        .wr_en       (wr_en),
        .wr_data     (wr_data)
    );

    csr_file u_csr_file (
        .clk           (clk),
        .wr_mscrstch   (wr_mscrstch),
        .csr_addr      (csr_addr),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .pc            (pc),
        .trap_take     (trap_take),
        .mret_take     (mret_take),
        .trap_cause    (trap_cause),
        .timer_pending (timer_pending),
        .read_data     (csr_rdata),
        .mstatus_mie   (mstatus_mie),
        .mie_mtie      (mie_mtie),
        .mip_mtip      (mip_mtip),
        .mtvec         (mtvec),
        .mepc          (mepc)
    );

    trap_ctrl u_trap_ctrl (
        .instr_valid    (instr_valid),
        .stall          (stall),
        .ecall          (ecall),
        .mret           (mret),
        .mstatus_mie    (mstatus_mie),
        .mie_mtie       (mie_mtie),
        .mip_mtip       (mip_mtip),
        .mtvec          (mtvec),
        .mepc           (mepc),
        .trap_take      (trap_take),
        .mret_take      (mret_take),
        .trap_cause     (trap_cause),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    clint_axil_regs u_clint_axil_regs (
        .clk         (clk),
        .wr_mscrstch (wr_mscrstch),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .wr_lo       (wr_lo),
        .wr_hi       (wr_hi),
        .cmp_lo      (cmp_lo),
        .cmp_hi      (cmp_hi),
        .wdata_out   (tmr_wdata),
        .mtime       (mtime),
        .mtimecmp    (mtimecmp)
    );

    clint_timer #(
        .TIMER_DIV (TIMER_DIV)
    ) u_clint_timer (
        .clk           (clk),
        .wr_mscrstch   (wr_mscrstch),
        .wr_lo         (wr_lo),
        .wr_hi         (wr_hi),
        .cmp_lo        (cmp_lo),
        .cmp_hi        (cmp_hi),
        .wdata_in      (tmr_wdata),
        .mtime         (mtime),
        .mtimecmp      (mtimecmp),
        .timer_pending (timer_pending)
    );

endmodule

/* clint_axil_regs.sv */
`timescale 1ns/100ps

module clint_axil_regs
    import machine_csr_pkg::*;
(
    input  logic       clk,
    input  logic       wr_mscrstch,
    input  bus_addr_t  awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  bus_data_t  wdata,
    input  logic       wvalid,
    output logic       wready,
    output logic [1:0] bresp,
    output logic       bvalid,
    input  logic       bready,
    input  bus_addr_t  araddr,
    input  logic       arvalid,
    output logic       arready,
    output bus_data_t  rdata,
    output logic [1:0] rresp,
    output logic       rvalid,
    input  logic       rready,
    output logic       wr_lo,
    output logic       wr_hi,
    output logic       cmp_lo,
    output logic       cmp_hi,
    output bus_data_t  wdata_out,
    input  xlen_t      mtime,
    input  xlen_t      mtimecmp
);

    logic      wr_accept;
    logic      wr_hs;
    logic      wr_ok;
    logic      rd_hs;
    bus_addr_t wr_off;
    bus_addr_t rd_off;

    // write channel, address and data taken together
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            wr_accept <= 1'b0;
            bvalid    <= 1'b0;
        end else begin
            wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign wr_hs   = wr_accept && awvalid && wvalid;
    assign wr_ok   = wr_hs && (awaddr[7:4] == 4'h0);
    assign wr_off  = {4'h0, awaddr[3:2], 2'b00}; // word aligned

    always_ff @(posedge clk) begin
        if (wr_hs) bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
    end

    assign wr_lo     = wr_ok && (wr_off == MTIME_LO);
    assign wr_hi     = wr_ok && (wr_off == MTIME_HI);
    assign cmp_lo    = wr_ok && (wr_off == MTIMECMP_LO);
    assign cmp_hi    = wr_ok && (wr_off == MTIMECMP_HI);
    assign wdata_out = wdata;

    // read channel
    assign arready = !rvalid;
    assign rd_hs   = arvalid && arready;
    assign rd_off  = {4'h0, araddr[3:2], 2'b00};

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            rvalid <= 1'b0;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            if (araddr[7:4] != 4'h0) begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end else begin
                rresp <= RESP_OKAY;
                case (rd_off)
                    MTIME_LO:    rdata <= mtime[31:0];
                    MTIME_HI:    rdata <= mtime[63:32];
                    MTIMECMP_LO: rdata <= mtimecmp[31:0];
                    default:     rdata <= mtimecmp[63:32];
                endcase
            end
        end
    end

    a_rdata_hold: assert property (@(posedge clk) disable iff (wr_mscrstch)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

/* clint_timer.sv */
`timescale 1ns/100ps

module clint_timer
    import machine_csr_pkg::*;
#(
    parameter int TIMER_DIV = 4
) (
    input  logic      clk,
    input  logic      wr_mscrstch,
    input  logic      wr_lo,
    input  logic      wr_hi,
    input  logic      cmp_lo,
    input  logic      cmp_hi,
    input  bus_data_t wdata_in,
    output xlen_t     mtime,
    output xlen_t     mtimecmp,
    output logic      timer_pending
);

    localparam int DIV_W = (TIMER_DIV > 1) ? $clog2(TIMER_DIV) : 1;

    logic [DIV_W-1:0] presc;
    logic             tick;
    xlen_t            mtime_nxt;

    assign tick = (presc == DIV_W'(TIMER_DIV - 1));

    always_ff @(posedge clk) begin
        if (wr_mscrstch || tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // a bus write to one half overrides that half of the increment
    always_comb begin
        mtime_nxt = mtime + {63'd0, tick};
        if (wr_lo) begin
            mtime_nxt[31:0] = wdata_in;
        end
        if (wr_hi) begin
            mtime_nxt[63:32] = wdata_in;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtime         <= '0;
            mtimecmp      <= '1; // no interrupt until software programs it
            timer_pending <= 1'b0;
        end else begin
            mtime <= mtime_nxt;
            if (cmp_lo) mtimecmp[31:0]  <= wdata_in;
            if (cmp_hi) mtimecmp[63:32] <= wdata_in;
            timer_pending <= (mtime >= mtimecmp);
        end
    end

endmodule

/* trap_ctrl.sv */
`timescale 1ns/100ps

module trap_ctrl
    import machine_csr_pkg::*;
(
    input  logic  instr_valid,
    input  logic  stall,
    input  logic  ecall,
    input  logic  mret,
    input  logic  mstatus_mie,
    input  logic  mie_mtie,
    input  logic  mip_mtip,
    input  xlen_t mtvec,
    input  xlen_t mepc,
    output logic  trap_take,
    output logic  mret_take,
    output xlen_t trap_cause,
    output logic  redirect_valid,
    output xlen_t redirect_pc
);

    logic issue;
    logic timer_trap;
    logic ecall_trap;

    assign issue = instr_valid && !stall;

    // timer interrupt wins over a synchronous ecall in the same slot
    assign timer_trap = issue && mip_mtip && mstatus_mie && mie_mtie;
    assign ecall_trap = issue && ecall && !timer_trap;

    assign trap_take  = timer_trap || ecall_trap;
    assign mret_take  = issue && mret && !trap_take;
    assign trap_cause = timer_trap ? CAUSE_MTIMER : CAUSE_ECALL_M;

    assign redirect_valid = trap_take || mret_take;
    assign redirect_pc    = trap_take ? mtvec : mepc; // direct mode only

endmodule

/* csr_file.sv */
`timescale 1ns/100ps

module csr_file
    import machine_csr_pkg::*;
(
    input  logic      clk,
    input  logic      wr_mscrstch,
    input  csr_addr_t csr_addr,
    input  logic      wr_en,
    input  xlen_t     wr_data,
    input  xlen_t     pc,
    input  logic      trap_take,
    input  logic      mret_take,
    input  xlen_t     trap_cause,
    input  logic      timer_pending,
    output xlen_t     read_data,
    output logic      mstatus_mie,
    output logic      mie_mtie,
    output logic      mip_mtip,
    output xlen_t     mtvec,
    output xlen_t     mepc
);

    logic        wr_fire;
    xlen_t       mcycle;
    xlen_t       mscratch;
    xlen_t       mcause;
    xlen_t       mstatus;
    logic [63:2] mtvec_base;
    logic [63:2] mepc_base;
    logic        mstatus_mpie;
    logic [1:0]  mstatus_mpp;
    logic [1:0]  mstatus_fs;
    logic        mstatus_sd;

    // an instruction that traps does not retire its csr write
    assign wr_fire = wr_en && !trap_take;

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mcycle <= '0;
        end else if (wr_fire && csr_addr == CSR_MCYCLE) begin
            mcycle <= wr_data;
        end else begin
            mcycle <= mcycle + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= 2'b00;
            mstatus_fs   <= 2'b00;
        end else if (trap_take) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= 2'b11; // trap taken from m-mode
        end else if (mret_take) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= 2'b00;
        end else if (wr_fire && csr_addr == CSR_MSTATUS) begin
            mstatus_mie  <= wr_data[3];
            mstatus_mpie <= wr_data[7];
            mstatus_mpp  <= wr_data[12:11];
            mstatus_fs   <= wr_data[14:13];
        end
    end

    assign mstatus_sd = (mstatus_fs == 2'b11); // xs is hardwired to zero
    assign mstatus = {mstatus_sd, 48'd0, mstatus_fs, mstatus_mpp, 3'd0,
                      mstatus_mpie, 3'd0, mstatus_mie, 3'd0};

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mtvec_base <= '0;
        end else if (wr_fire && csr_addr == CSR_MTVEC) begin
            mtvec_base <= wr_data[63:2];
        end
    end

    assign mtvec = {mtvec_base, 2'b00}; // mode fixed to direct

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mepc_base <= '0;
            mcause    <= '0;
        end else if (trap_take) begin
            mepc_base <= pc[63:2];
            mcause    <= trap_cause;
        end else if (wr_fire) begin
            if (csr_addr == CSR_MEPC) begin
                mepc_base <= wr_data[63:2];
            end
            if (csr_addr == CSR_MCAUSE) begin
                mcause <= wr_data;
            end
        end
    end

    assign mepc = {mepc_base, 2'b00};

    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mie_mtie <= 1'b0;
            mscratch <= '0;
        end else if (wr_fire) begin
            if (csr_addr == CSR_MIE) begin
                mie_mtie <= wr_data[7];
            end
            if (csr_addr == CSR_MSCRATCH) begin
                mscratch <= wr_data;
            end
        end
    end

    // mip.mtip mirrors the timer, software writes are ignored
    always_ff @(posedge clk) begin
        if (wr_mscrstch) begin
            mip_mtip <= 1'b0;
        end else begin
            mip_mtip <= timer_pending;
        end
    end

    always_comb begin
        case (csr_addr)
            CSR_MCYCLE:   read_data = mcycle;
            CSR_MSTATUS:  read_data = mstatus;
            CSR_MTVEC:    read_data = mtvec;
            CSR_MEPC:     read_data = mepc;
            CSR_MCAUSE:   read_data = mcause;
            CSR_MIE:      read_data = {56'd0, mie_mtie, 7'd0};
            CSR_MIP:      read_data = {56'd0, mip_mtip, 7'd0};
            CSR_MSCRATCH: read_data = mscratch;
            default:      read_data = '0; // unmapped
        endcase
    end

    // trap and mret come from separate decode paths in trap_ctrl
    a_trap_mret_excl: assert property (@(posedge clk) disable iff (wr_mscrstch)
        !(trap_take && mret_take));

endmodule

/* csr_access.sv */
`timescale 1ns/100ps

module csr_access
    import machine_csr_pkg::*;
(
    input  logic    clk,
    input  logic    wr_mscrstch,
    input  csr_op_e csr_op,
    input  xlen_t   csr_src,
    input  xlen_t   old_value,
    input  logic    stall,
    input  logic    instr_valid,
    output logic    wr_en,
    output xlen_t   wr_data
);

    logic issue;
    logic src_zero;

    assign issue    = instr_valid && !stall;
    assign src_zero = (csr_src == '0);

    always_comb begin
        wr_data = old_value;
        wr_en   = 1'b0;
        case (csr_op)
            CSR_RW: begin
                wr_data = csr_src;
                wr_en   = issue;
            end
            CSR_RS: begin
                wr_data = old_value | csr_src;
                wr_en   = issue && !src_zero; // rs1 = x0 means read only
            end
            CSR_RC: begin
                wr_data = old_value & ~csr_src;
                wr_en   = issue && !src_zero;
            end
            default: wr_en = 1'b0;
        endcase
    end

    // the pipeline must present a defined op whenever it claims a valid instruction
    a_op_known: assert property (@(posedge clk) disable iff (wr_mscrstch)
        instr_valid |-> !$isunknown(csr_op));

endmodule

/* machine_csr_pkg.sv */
package machine_csr_pkg;

    typedef logic [63:0] xlen_t;     // architectural register word
    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] bus_data_t; // axi4-lite data lane
    typedef logic [7:0]  bus_addr_t; // offset inside the timer block

    // machine csr indices
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;

    localparam xlen_t CAUSE_ECALL_M = 64'd11;
    localparam xlen_t CAUSE_MTIMER  = {1'b1, 63'd7}; // interrupt flag in bit 63

    localparam bus_addr_t MTIME_LO    = 8'h00;
    localparam bus_addr_t MTIME_HI    = 8'h04;
    localparam bus_addr_t MTIMECMP_LO = 8'h08;
    localparam bus_addr_t MTIMECMP_HI = 8'h0C;

    typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csr_op_e;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage
